//--- hw/lock_pkg.sv
`default_nettype none

package lock_pkg;

    typedef logic [3:0]  key_t;
    typedef logic [3:0]  digit_t;
    typedef logic [11:0] display_t;  // three digits, newest in the low nibble
    typedef logic [1:0]  tries_t;

    localparam key_t KEY_ENTER = 4'hA;
    localparam key_t KEY_SET   = 4'hB;
    localparam key_t KEY_CLEAR = 4'hC;
    localparam key_t KEY_BACK  = 4'hD;

    localparam digit_t   DIGIT_BLANK   = 4'hF;
    localparam display_t DISPLAY_BLANK = 12'hFFF;
    localparam display_t DISPLAY_PASS  = 12'hBCC;
    localparam display_t DISPLAY_SET   = 12'hDDD;
    localparam display_t SECRET_RESET  = 12'h246;

    localparam tries_t MAX_TRIES = 2'd3;

    // lockout seconds in BCD, index 3 covers every later lockout
    localparam logic [3:0][7:0] LOCKOUT_BCD = {8'h60, 8'h20, 8'h10, 8'h05};

    localparam int TICK_CYCLES_DEFAULT = 50_000_000;  // one second at 50 MHz

    localparam int TONE_KEY_HALF  = 50_000;
    localparam int TONE_KEY_DUR   = 10_000_000;
    localparam int TONE_OK_HALF   = 25_000;
    localparam int TONE_OK_DUR    = 30_000_000;
    localparam int TONE_FAIL_HALF = 100_000;
    localparam int TONE_FAIL_DUR  = 15_000_000;
    localparam int TONE_TICK_HALF = 100_000;
    localparam int TONE_TICK_DUR  = 5_000_000;

    typedef enum logic [2:0] {
        TONE_NONE,
        TONE_KEY,
        TONE_OK,
        TONE_FAIL,
        TONE_TICK
    } tone_t;

    typedef enum logic [1:0] {
        ENTRY,
        SET_ENTRY,
        PASS,
        LOCKED
    } entry_state_t;

    // returns {mapped, key code}; multi-bit and unused words give mapped = 0
    function automatic logic [4:0] decode_key(input logic [15:0] word);
        logic [4:0] res;
        case (word)
            16'h0008: res = {1'b1, 4'd0};
            16'h0080: res = {1'b1, 4'd1};
            16'h0040: res = {1'b1, 4'd2};
            16'h0020: res = {1'b1, 4'd3};
            16'h0800: res = {1'b1, 4'd4};
            16'h0400: res = {1'b1, 4'd5};
            16'h0200: res = {1'b1, 4'd6};
            16'h8000: res = {1'b1, 4'd7};
            16'h4000: res = {1'b1, 4'd8};
            16'h2000: res = {1'b1, 4'd9};
            16'h0001: res = {1'b1, KEY_ENTER};
            16'h0010: res = {1'b1, KEY_SET};
            16'h0100: res = {1'b1, KEY_CLEAR};
            16'h1000: res = {1'b1, KEY_BACK};
            default:  res = 5'h00;
        endcase
        return res;
    endfunction

endpackage

`default_nettype wire

//--- hw/keypad_decoder.sv
`timescale 1ns/1ps
`default_nettype none

module keypad_decoder (
    input  wire                 clk,
    input  wire                 rst_n,
    input  wire  [15:0]         onehot,
    output logic                key_valid,
    output lock_pkg::key_t      key
);

    logic [15:0] prev;     // last cycle's keypad word
    logic [4:0]  decoded;  // {mapped, code}
    logic        press;

    assign decoded = lock_pkg::decode_key(onehot);

    // fresh single-key press only, release must come first
    assign press = decoded[4] && (prev == 16'h0000);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            prev      <= 16'h0000;
            key_valid <= 1'b0;
        end else begin
            prev      <= onehot;
            key_valid <= press;
        end
    end

    // key code is only sampled by consumers with key_valid
    always_ff @(posedge clk) begin
        if (press) begin
            key <= decoded[3:0];
        end
    end

endmodule

`default_nettype wire

//--- hw/code_entry.sv
`timescale 1ns/1ps
`default_nettype none

module code_entry (
    input  wire                     clk,
    input  wire                     rst_n,
    input  wire                     key_valid,
    input  wire  lock_pkg::key_t    key,
    input  wire  [7:0]              count_bcd,
    input  wire                     lock_done,
    output lock_pkg::display_t      display,
    output lock_pkg::tries_t        tries,
    output logic                    locked,
    output logic                    tone_req,
    output lock_pkg::tone_t         tone_sel,
    output logic                    lock_start,
    output logic [7:0]              lock_bcd
);

    lock_pkg::entry_state_t state;
    lock_pkg::display_t     disp_q;
    lock_pkg::display_t     secret;
    lock_pkg::display_t     shift_base;
    logic [1:0]             digits;    // digits entered so far
    logic [1:0]             lockouts;  // saturates at 3
    logic                   is_digit;
    logic                   full;

    assign is_digit   = (key <= 4'd9);
    assign full       = (digits == 2'd3);
    assign shift_base = (digits == 2'd0) ? lock_pkg::DISPLAY_BLANK : disp_q;  // drop DDD/blank
    assign locked     = (state == lock_pkg::LOCKED);

    // lock_bcd covers the cycle before the timer has loaded its count
    assign display = locked ? {lock_pkg::DIGIT_BLANK, lock_start ? lock_bcd : count_bcd}
                            : disp_q;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state      <= lock_pkg::ENTRY;
            disp_q     <= lock_pkg::DISPLAY_BLANK;
            secret     <= lock_pkg::SECRET_RESET;
            digits     <= 2'd0;
            lockouts   <= 2'd0;
            tries      <= 2'd0;
            tone_req   <= 1'b0;
            tone_sel   <= lock_pkg::TONE_NONE;
            lock_start <= 1'b0;
            lock_bcd   <= 8'h00;
        end else begin
            tone_req   <= 1'b0;
            lock_start <= 1'b0;
            case (state)
                lock_pkg::ENTRY, lock_pkg::SET_ENTRY: begin
                    if (key_valid && is_digit && !full) begin
                        disp_q   <= {shift_base[7:0], key};
                        digits   <= digits + 2'd1;
                        tone_req <= 1'b1;
                        tone_sel <= lock_pkg::TONE_KEY;
                    end else if (key_valid && key == lock_pkg::KEY_BACK && digits != 2'd0) begin
                        disp_q   <= {lock_pkg::DIGIT_BLANK, disp_q[11:4]};
                        digits   <= digits - 2'd1;
                        tone_req <= 1'b1;
                        tone_sel <= lock_pkg::TONE_KEY;
                    end else if (key_valid && key == lock_pkg::KEY_CLEAR) begin
                        disp_q   <= lock_pkg::DISPLAY_BLANK;
                        digits   <= 2'd0;
                        tone_req <= 1'b1;
                        tone_sel <= lock_pkg::TONE_KEY;
                    end else if (key_valid && key == lock_pkg::KEY_SET) begin
                        state    <= lock_pkg::SET_ENTRY;
                        disp_q   <= lock_pkg::DISPLAY_SET;
                        digits   <= 2'd0;
                        tries    <= 2'd0;
                        tone_req <= 1'b1;
                        tone_sel <= lock_pkg::TONE_KEY;
                    end else if (key_valid && key == lock_pkg::KEY_ENTER && full) begin
                        digits   <= 2'd0;
                        tone_req <= 1'b1;
                        if (state == lock_pkg::SET_ENTRY) begin
                            secret   <= disp_q;  // new code stored
                            disp_q   <= lock_pkg::DISPLAY_BLANK;
                            state    <= lock_pkg::ENTRY;
                            tone_sel <= lock_pkg::TONE_OK;
                        end else if (disp_q == secret) begin
                            disp_q   <= lock_pkg::DISPLAY_PASS;
                            state    <= lock_pkg::PASS;
                            tone_sel <= lock_pkg::TONE_OK;
                        end else begin
                            disp_q   <= lock_pkg::DISPLAY_BLANK;
                            tone_sel <= lock_pkg::TONE_FAIL;
                            if (tries == lock_pkg::MAX_TRIES - 2'd1) begin
                                // third miss, start lockout
                                state      <= lock_pkg::LOCKED;
                                tries      <= 2'd0;
                                lock_start <= 1'b1;
                                lock_bcd   <= lock_pkg::LOCKOUT_BCD[lockouts];
                                if (lockouts != 2'd3) begin
                                    lockouts <= lockouts + 2'd1;
                                end
                            end else begin
                                tries <= tries + 2'd1;
                            end
                        end
                    end
                end
                lock_pkg::PASS: begin
                    if (key_valid && key == lock_pkg::KEY_CLEAR) begin
                        state    <= lock_pkg::ENTRY;
                        disp_q   <= lock_pkg::DISPLAY_BLANK;
                        tone_req <= 1'b1;
                        tone_sel <= lock_pkg::TONE_KEY;
                    end
                end
                lock_pkg::LOCKED: begin
                    if (lock_done) begin  // keys are dropped until here
                        state  <= lock_pkg::ENTRY;
                        disp_q <= lock_pkg::DISPLAY_BLANK;
                        digits <= 2'd0;
                    end
                end
                default: state <= lock_pkg::ENTRY;
            endcase
        end
    end

endmodule

`default_nettype wire

//--- hw/lockout_timer.sv
`timescale 1ns/1ps
`default_nettype none

module lockout_timer #(
    parameter int TICK_CYCLES = lock_pkg::TICK_CYCLES_DEFAULT
) (
    input  wire         clk,
    input  wire         rst_n,
    input  wire         lock_start,
    input  wire  [7:0]  lock_bcd,
    output logic [7:0]  count_bcd,
    output logic        sec_tick,
    output logic        lock_done
);

    logic [31:0] presc;    // cycles within the current second
    logic        running;
    logic        second;

    assign second = running && (presc == 32'(TICK_CYCLES - 1));

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            presc     <= 32'd0;
            running   <= 1'b0;
            count_bcd <= 8'h00;
            sec_tick  <= 1'b0;
            lock_done <= 1'b0;
        end else begin
            sec_tick  <= 1'b0;
            lock_done <= 1'b0;
            if (lock_start) begin
                presc     <= 32'd0;
                running   <= 1'b1;
                count_bcd <= lock_bcd;
            end else if (second) begin
                presc    <= 32'd0;
                sec_tick <= 1'b1;
                if (count_bcd[3:0] == 4'd0) begin
                    count_bcd <= {count_bcd[7:4] - 4'd1, 4'd9};  // borrow from tens
                end else begin
                    count_bcd[3:0] <= count_bcd[3:0] - 4'd1;
                end
                if (count_bcd == 8'h01) begin  // stepping to 00
                    running   <= 1'b0;
                    lock_done <= 1'b1;
                end
            end else if (running) begin
                presc <= presc + 32'd1;
            end
        end
    end

endmodule

`default_nettype wire

//--- hw/buzzer_sequencer.sv
`timescale 1ns/1ps
`default_nettype none

module buzzer_sequencer #(
    parameter int TICK_CYCLES = lock_pkg::TICK_CYCLES_DEFAULT
) (
    input  wire                     clk,
    input  wire                     rst_n,
    input  wire                     tone_req,
    input  wire  lock_pkg::tone_t   tone_sel,
    input  wire                     sec_tick,
    output logic                    buzzer
);

    lock_pkg::tone_t tone;        // active tone, NONE when silent
    lock_pkg::tone_t next_tone;
    logic [31:0]     per_cnt;
    logic [31:0]     dur_cnt;
    logic [31:0]     half;
    logic [31:0]     dur;
    logic            start;
    logic            mute;

    // cycle counts follow the tick rate, never below one cycle
    function automatic logic [31:0] scaled(input int cycles);
        int div;
        div = lock_pkg::TICK_CYCLES_DEFAULT / TICK_CYCLES;
        if (div < 1) begin
            div = 1;
        end
        return (cycles / div < 1) ? 32'd1 : 32'(cycles / div);
    endfunction

    always_comb begin
        case (tone)
            lock_pkg::TONE_KEY: begin
                half = scaled(lock_pkg::TONE_KEY_HALF);
                dur  = scaled(lock_pkg::TONE_KEY_DUR);
            end
            lock_pkg::TONE_OK: begin
                half = scaled(lock_pkg::TONE_OK_HALF);
                dur  = scaled(lock_pkg::TONE_OK_DUR);
            end
            lock_pkg::TONE_FAIL: begin
                half = scaled(lock_pkg::TONE_FAIL_HALF);
                dur  = scaled(lock_pkg::TONE_FAIL_DUR);
            end
            lock_pkg::TONE_TICK: begin
                half = scaled(lock_pkg::TONE_TICK_HALF);
                dur  = scaled(lock_pkg::TONE_TICK_DUR);
            end
            default: begin
                half = 32'd1;
                dur  = 32'd1;
            end
        endcase
    end

    assign start     = tone_req || sec_tick;
    assign next_tone = tone_req ? tone_sel : lock_pkg::TONE_TICK;  // entry request wins

    // fail tone is silent in its middle third, two bursts
    assign mute = (tone == lock_pkg::TONE_FAIL) && (dur_cnt >= dur / 3)
                  && (dur_cnt < (dur / 3) * 2);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            tone    <= lock_pkg::TONE_NONE;
            per_cnt <= 32'd0;
            dur_cnt <= 32'd0;
            buzzer  <= 1'b0;
        end else if (start) begin
            tone    <= next_tone;  // restart on any new request
            per_cnt <= 32'd0;
            dur_cnt <= 32'd0;
            buzzer  <= (next_tone != lock_pkg::TONE_NONE);
        end else if (tone != lock_pkg::TONE_NONE) begin
            dur_cnt <= dur_cnt + 32'd1;
            per_cnt <= per_cnt + 32'd1;
            if (dur_cnt >= dur - 32'd1) begin
                tone   <= lock_pkg::TONE_NONE;
                buzzer <= 1'b0;
            end else if (mute) begin
                per_cnt <= 32'd0;
                buzzer  <= 1'b0;
            end else if (per_cnt >= half - 32'd1) begin
                per_cnt <= 32'd0;
                buzzer  <= ~buzzer;
            end
        end else begin
            buzzer <= 1'b0;
        end
    end

endmodule

`default_nettype wire

//--- hw/lock_top.sv
`timescale 1ns/1ps
`default_nettype none

module lock_top #(
    parameter int TICK_CYCLES = lock_pkg::TICK_CYCLES_DEFAULT
) (
    input  wire                     clk,
    input  wire                     rst_n,
    input  wire  [15:0]             onehot,
    output lock_pkg::display_t      display,
    output lock_pkg::tries_t        tries,
    output logic                    locked,
    output logic                    buzzer
);

    logic            key_valid;
    lock_pkg::key_t  key;
    logic [7:0]      count_bcd;
    logic            lock_done;
    logic            tone_req;
    lock_pkg::tone_t tone_sel;
    logic            lock_start;
    logic [7:0]      lock_bcd;
    logic            sec_tick;

    keypad_decoder u_decoder (
        .clk       (clk),
        .rst_n     (rst_n),
        .onehot    (onehot),
        .key_valid (key_valid),
        .key       (key)
    );

    code_entry u_entry (
        .clk        (clk),
        .rst_n      (rst_n),
        .key_valid  (key_valid),
        .key        (key),
        .count_bcd  (count_bcd),
        .lock_done  (lock_done),
        .display    (display),
        .tries      (tries),
        .locked     (locked),
        .tone_req   (tone_req),
        .tone_sel   (tone_sel),
        .lock_start (lock_start),
        .lock_bcd   (lock_bcd)
    );

    lockout_timer #(
        .TICK_CYCLES (TICK_CYCLES)
    ) u_timer (
        .clk        (clk),
        .rst_n      (rst_n),
        .lock_start (lock_start),
        .lock_bcd   (lock_bcd),
        .count_bcd  (count_bcd),
        .sec_tick   (sec_tick),
        .lock_done  (lock_done)
    );

    buzzer_sequencer #(
        .TICK_CYCLES (TICK_CYCLES)
    ) u_buzzer (
        .clk      (clk),
        .rst_n    (rst_n),
        .tone_req (tone_req),
        .tone_sel (tone_sel),
        .sec_tick (sec_tick),
        .buzzer   (buzzer)
    );

endmodule

`default_nettype wire

//--- bench/lock_asserts.sv
`timescale 1ns/1ps
`default_nettype none

module lock_asserts (
    input wire                      clk,
    input wire                      rst_n,
    input wire  lock_pkg::display_t display,
    input wire  lock_pkg::tries_t   tries,
    input wire                      locked,
    input wire                      buzzer,
    input wire                      key_valid,
    input wire                      tone_req,
    input wire                      sec_tick
);

    logic [7:0] quiet_cycles;  // saturating count since the last tone request

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            quiet_cycles <= 8'hFF;
        end else if (tone_req || sec_tick) begin
            quiet_cycles <= 8'd0;
        end else if (quiet_cycles != 8'hFF) begin
            quiet_cycles <= quiet_cycles + 8'd1;
        end
    end

    // pass and set patterns are the only non-BCD words
    function automatic bit display_ok(input lock_pkg::display_t d);
        bit ok;
        ok = 1'b1;
        for (int i = 0; i < 3; i++) begin
            if (d[i*4 +: 4] > 4'd9 && d[i*4 +: 4] != 4'hF) begin
                ok = 1'b0;
            end
        end
        return ok || d == lock_pkg::DISPLAY_PASS || d == lock_pkg::DISPLAY_SET;
    endfunction

    display_digits: assert property (@(posedge clk) disable iff (!rst_n)
        display_ok(display))
        else $error("display holds a nibble that is neither BCD nor blank");

    tries_bound: assert property (@(posedge clk) disable iff (!rst_n)
        key_valid |=> !(tries == 2'd3 && !locked))
        else $error("tries reached three without a lockout");

    // longest tone lasts 60 cycles at the bench tick rate
    buzzer_silent: assert property (@(posedge clk) disable iff (!rst_n)
        (quiet_cycles >= 8'd64) |-> !buzzer)
        else $error("buzzer still active after every tone has ended");

endmodule

bind lock_top lock_asserts u_asserts (
    .clk       (clk),
    .rst_n     (rst_n),
    .display   (display),
    .tries     (tries),
    .locked    (locked),
    .buzzer    (buzzer),
    .key_valid (key_valid),
    .tone_req  (tone_req),
    .sec_tick  (sec_tick)
);

`default_nettype wire

//--- bench/lock_tb.sv
`timescale 1ns/1ps
`default_nettype none

module lock_tb;

    logic                 clk;
    logic                 rst_n;
    logic [15:0]          onehot;
    lock_pkg::display_t   display;
    lock_pkg::tries_t     tries;
    logic                 locked;
    logic                 buzzer;

    int                   seed = 20428;
    bit                   check_en;
    int                   buzz_toggles;
    logic                 buzz_prev;
    logic [11:0]          new_code;

    // reference model of the lock
    lock_pkg::entry_state_t m_mode;
    logic [11:0]            m_disp;
    logic [11:0]            m_secret;
    logic [1:0]             m_tries;
    logic                   m_locked;
    logic [7:0]             m_lock_bcd;
    int                     m_digits;
    int                     m_lockouts;

    lock_top #(
        .TICK_CYCLES (100)
    ) dut (
        .clk     (clk),
        .rst_n   (rst_n),
        .onehot  (onehot),
        .display (display),
        .tries   (tries),
        .locked  (locked),
        .buzzer  (buzzer)
    );

    always #2 clk = ~clk;

    task automatic fail_now(input string why);
        $display("%s", why);
        $display("Test failed");
        $fatal(1);
    endtask

    task automatic report_value(input string name, input logic [11:0] got,
                                input logic [11:0] exp);
        fail_now($sformatf("** Error: %s = 0x%h, expected 0x%h", name, got, exp));
    endtask

    function automatic logic [15:0] key_word(input logic [3:0] k);
        case (k)
            4'd0:    return 16'h0008;
            4'd1:    return 16'h0080;
            4'd2:    return 16'h0040;
            4'd3:    return 16'h0020;
            4'd4:    return 16'h0800;
            4'd5:    return 16'h0400;
            4'd6:    return 16'h0200;
            4'd7:    return 16'h8000;
            4'd8:    return 16'h4000;
            4'd9:    return 16'h2000;
            4'hA:    return 16'h0001;  // enter
            4'hB:    return 16'h0010;  // set
            4'hC:    return 16'h0100;  // clear
            default: return 16'h1000;  // back
        endcase
    endfunction

    function automatic logic [7:0] lockout_seconds(input int n);
        case (n)
            0:       return 8'h05;
            1:       return 8'h10;
            2:       return 8'h20;
            default: return 8'h60;
        endcase
    endfunction

    function automatic logic [7:0] bcd_dec(input logic [7:0] b);
        if (b[3:0] == 4'd0) begin
            return {b[7:4] - 4'd1, 4'd9};
        end
        return {b[7:4], b[3:0] - 4'd1};
    endfunction

    function automatic logic [3:0] rand_digit();
        return 4'($unsigned($random(seed)) % 10);
    endfunction

    // three random digits that never equal the avoided code
    function automatic logic [11:0] random_code(input logic [11:0] avoid);
        logic [11:0] c;
        c = {rand_digit(), rand_digit(), rand_digit()};
        if (c == avoid) begin
            c[3:0] = (c[3:0] == 4'd9) ? 4'd0 : c[3:0] + 4'd1;
        end
        return c;
    endfunction

    // advances the model by one key and returns 1 when a tone is due
    function automatic bit expected_state(input logic [3:0] k);
        bit          acc;
        logic [11:0] base;
        acc  = 1'b0;
        base = (m_digits == 0) ? lock_pkg::DISPLAY_BLANK : m_disp;
        case (m_mode)
            lock_pkg::ENTRY, lock_pkg::SET_ENTRY: begin
                if (k <= 4'd9) begin
                    if (m_digits < 3) begin
                        m_disp = {base[7:0], k};
                        m_digits++;
                        acc = 1'b1;
                    end
                end else if (k == lock_pkg::KEY_BACK) begin
                    if (m_digits > 0) begin
                        m_disp = {4'hF, m_disp[11:4]};
                        m_digits--;
                        acc = 1'b1;
                    end
                end else if (k == lock_pkg::KEY_CLEAR) begin
                    m_disp   = lock_pkg::DISPLAY_BLANK;
                    m_digits = 0;
                    acc      = 1'b1;
                end else if (k == lock_pkg::KEY_SET) begin
                    m_mode   = lock_pkg::SET_ENTRY;
                    m_disp   = lock_pkg::DISPLAY_SET;
                    m_digits = 0;
                    m_tries  = 2'd0;
                    acc      = 1'b1;
                end else if (k == lock_pkg::KEY_ENTER && m_digits == 3) begin
                    acc      = 1'b1;
                    m_digits = 0;
                    if (m_mode == lock_pkg::SET_ENTRY) begin
                        m_secret = m_disp;
                        m_disp   = lock_pkg::DISPLAY_BLANK;
                        m_mode   = lock_pkg::ENTRY;
                    end else if (m_disp == m_secret) begin
                        m_disp = lock_pkg::DISPLAY_PASS;
                        m_mode = lock_pkg::PASS;
                    end else begin
                        m_disp = lock_pkg::DISPLAY_BLANK;
                        if (m_tries == 2'd2) begin  // third miss
                            m_mode     = lock_pkg::LOCKED;
                            m_locked   = 1'b1;
                            m_tries    = 2'd0;
                            m_lock_bcd = lockout_seconds(m_lockouts);
                            m_lockouts++;
                        end else begin
                            m_tries = m_tries + 2'd1;
                        end
                    end
                end
            end
            lock_pkg::PASS: begin
                if (k == lock_pkg::KEY_CLEAR) begin
                    m_mode = lock_pkg::ENTRY;
                    m_disp = lock_pkg::DISPLAY_BLANK;
                    acc    = 1'b1;
                end
            end
            default: acc = 1'b0;  // key dropped while locked
        endcase
        return acc;
    endfunction

    function automatic logic [11:0] exp_display();
        return m_locked ? {4'hF, m_lock_bcd} : m_disp;
    endfunction

    function automatic bit settled();
        return display == exp_display() && tries == m_tries && locked == m_locked;
    endfunction

    task automatic compare_outputs();
        assert (display == exp_display()) else report_value("display", display, exp_display());
        assert (tries == m_tries) else report_value("tries", 12'(tries), 12'(m_tries));
        assert (locked == m_locked) else report_value("locked", 12'(locked), 12'(m_locked));
    endtask

    always @(negedge clk) begin
        if (check_en) begin
            compare_outputs();
        end
    end

    always @(negedge clk) begin
        if (buzzer !== buzz_prev) begin
            buzz_toggles++;
        end
        buzz_prev = buzzer;
    end

    task automatic press(input logic [3:0] k);
        bit acc;
        int n;
        int toggles_before;
        check_en = 1'b0;
        acc = expected_state(k);
        if (acc) begin
            wait_quiet();  // so any toggle below comes from this key
        end
        @(posedge clk);
        onehot <= key_word(k);
        toggles_before = buzz_toggles;
        repeat (3) @(posedge clk);
        onehot <= 16'h0000;
        repeat (3) @(posedge clk);
        for (n = 0; n < 10; n++) begin  // bounded settle
            @(negedge clk);
            if (settled()) begin
                break;
            end
        end
        check_en = 1'b1;
        @(negedge clk);
        @(posedge clk);
        if (acc) begin
            assert (buzz_toggles != toggles_before)
                else fail_now("buzzer did not toggle after an accepted key");
        end
    endtask

    task automatic enter_code(input logic [11:0] code);
        press(code[11:8]);
        press(code[7:4]);
        press(code[3:0]);
        press(lock_pkg::KEY_ENTER);
    endtask

    task automatic wait_quiet();
        int quiet;
        int n;
        quiet = 0;
        for (n = 0; n < 400 && quiet < 70; n++) begin  // longest tone is 60 cycles
            @(negedge clk);
            quiet = buzzer ? 0 : quiet + 1;
        end
        assert (quiet >= 70) else fail_now("buzzer kept sounding after the longest tone");
    endtask

    task automatic run_lockout();
        logic [11:0] prev;
        int          limit;
        int          n;
        bit          saw_zero;
        press(4'd7);  // dropped while locked
        press(lock_pkg::KEY_SET);
        check_en = 1'b0;
        @(negedge clk);
        prev     = display;
        saw_zero = 1'b0;
        limit    = (int'(m_lock_bcd[7:4]) * 10 + int'(m_lock_bcd[3:0]) + 1) * 100 + 50;
        for (n = 0; n < limit && locked; n++) begin
            @(negedge clk);
            if (locked && display != prev) begin
                assert (display == {4'hF, bcd_dec(prev[7:0])})
                    else report_value("display", display, {4'hF, bcd_dec(prev[7:0])});
                prev = display;
            end
            if (locked && display == 12'hF00) begin
                saw_zero = 1'b1;
            end
        end
        assert (!locked) else fail_now("lockout did not end within its timeout");
        assert (saw_zero) else fail_now("lockout count never reached 00");
        m_locked = 1'b0;
        m_mode   = lock_pkg::ENTRY;
        m_disp   = lock_pkg::DISPLAY_BLANK;
        m_digits = 0;
        check_en = 1'b1;
    endtask

    initial begin
        clk          = 1'b0;
        rst_n        = 1'b0;
        onehot       = 16'h0000;
        check_en     = 1'b0;
        buzz_toggles = 0;
        buzz_prev    = 1'b0;
        m_mode       = lock_pkg::ENTRY;
        m_disp       = 12'hFFF;
        m_secret     = 12'h246;
        m_tries      = 2'd0;
        m_locked     = 1'b0;
        m_lock_bcd   = 8'h00;
        m_digits     = 0;
        m_lockouts   = 0;
        repeat (16) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        assert (buzzer == 1'b0) else report_value("buzzer", 12'(buzzer), 12'h000);
        check_en = 1'b1;

        // digit entry with backspace
        press(lock_pkg::KEY_BACK);
        for (int i = 0; i < 8; i++) begin
            press(rand_digit());
            if (rand_digit() < 4'd3) begin
                press(lock_pkg::KEY_BACK);
            end
        end
        press(lock_pkg::KEY_CLEAR);

        enter_code(12'h246);  // reset secret
        press(lock_pkg::KEY_CLEAR);
        wait_quiet();

        repeat (3) enter_code(random_code(m_secret));
        run_lockout();
        repeat (3) enter_code(random_code(m_secret));
        run_lockout();  // longer second lockout

        press(lock_pkg::KEY_SET);
        new_code = random_code(12'h246);
        enter_code(new_code);
        enter_code(new_code);
        press(lock_pkg::KEY_CLEAR);
        enter_code(12'h246);  // old secret now wrong
        wait_quiet();

        $display("Test completed successfully");
        $finish;
    end

endmodule

`default_nettype wire

//--- list.f
hw/lock_pkg.sv
hw/keypad_decoder.sv
hw/code_entry.sv
hw/lockout_timer.sv
hw/buzzer_sequencer.sv
hw/lock_top.sv
bench/lock_asserts.sv
bench/lock_tb.sv

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module lock_tb -f list.f

out=$(./obj_dir/Vlock_tb 2>&1 || true)
echo "$out"

if echo "$out" | grep -q "Test completed successfully"; then
    exit 0
else
    exit 1
fi
